// ==== flist.f ====
+incdir+.
pbkdf_pkg.sv
sha256_k_rom.sv
sha256_round_core.sv
pbkdf_sequencer.sv
pbkdf_engine.sv
tb_pbkdf_engine.sv

// ==== Bender.yml ====
package:
  name: pbkdf_engine

sources:
  - include_dirs:
      - .
    files:
      - pbkdf_pkg.sv
      - sha256_k_rom.sv
      - sha256_round_core.sv
      - pbkdf_sequencer.sv
      - pbkdf_engine.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pbkdf_engine.sv

// ==== tb_sha256_model.svh ====
////////////////////////////////////////////////////////////////////////////
// Testbench reference model for SHA-256 and PBKDF2-HMAC-SHA256
// Header is password and salt, one iteration, four 256-bit key blocks
////////////////////////////////////////////////////////////////////////////
`ifndef TB_SHA256_MODEL_SVH
`define TB_SHA256_MODEL_SVH
`include "pbkdf_params.svh"

// Round constants, K[0] in the top word
localparam logic [2047:0] sha_k = {
	32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
	32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
	32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
	32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
	32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
	32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
	32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
	32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
	32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
	32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
	32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
	32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
	32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
	32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
	32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
	32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
};

function automatic logic [31:0] ror(input logic [31:0] x, input int n);
	return (x >> n) | (x << (32 - n));
endfunction

// One compression, words in SHA order from bit 0 up
function automatic logic [255:0] sha_block(input logic [255:0] st, input logic [511:0] blk);
	logic [31:0] w [0:63];
	logic [31:0] v [0:7];						// a..h
	logic [31:0] s0, s1, t1, t2;
	logic [255:0] res;
	for (int t = 0; t < 64; t++) begin
		if (t < 16) begin
			w[t] = blk[32*t +: 32];
		end else begin
			s0 = ror(w[t-15], 7) ^ ror(w[t-15], 18) ^ (w[t-15] >> 3);
			s1 = ror(w[t-2], 17) ^ ror(w[t-2], 19) ^ (w[t-2] >> 10);
			w[t] = w[t-16] + s0 + w[t-7] + s1;
		end
	end
	for (int i = 0; i < 8; i++)
		v[i] = st[32*i +: 32];
	for (int t = 0; t < 64; t++) begin
		s1 = ror(v[4], 6) ^ ror(v[4], 11) ^ ror(v[4], 25);
		t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + sha_k[32*(63-t) +: 32] + w[t];
		s0 = ror(v[0], 2) ^ ror(v[0], 13) ^ ror(v[0], 22);
		t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
		for (int i = 7; i > 0; i--)
			v[i] = v[i-1];						// Shift a..g into b..h
		v[4] = v[4] + t1;						// e = d + t1
		v[0] = t1 + t2;
	end
	for (int i = 0; i < 8; i++)
		res[32*i +: 32] = st[32*i +: 32] + v[i];
	return res;
endfunction

// Full hash of n message words, up to 45 words
function automatic logic [255:0] sha256_words(input logic [1535:0] m, input int n);
	logic [1535:0] p;
	logic [255:0] st;
	int nblk;
	p = '0;
	for (int j = 0; j < n; j++)
		p[32*j +: 32] = m[32*j +: 32];
	p[32*n +: 32] = 32'h80000000;				// Terminating one bit
	nblk = (n + 3 + 15) / 16;					// Room for marker and 64-bit length
	p[32*(16*nblk-1) +: 32] = 32 * n;			// Bit length, low word
	st = `SHA_IV;
	for (int b = 0; b < nblk; b++)
		st = sha_block(st, p[512*b +: 512]);
	return st;
endfunction

// Key block idx (0..3) for a 20-word header, counter is idx + 1
function automatic logic [255:0] pbkdf_block(input logic [639:0] hdr, input int idx);
	logic [1535:0] m;
	logic [255:0] key;
	logic [255:0] inner;
	m = '0;
	m[639:0] = hdr;
	key = sha256_words(m, 20);					// Password longer than a block
	m = '0;
	for (int j = 0; j < 16; j++)
		m[32*j +: 32] = ((j < 8) ? key[32*j +: 32] : 32'h0) ^ {4{`IPAD_BYTE}};
	m[512 +: 640] = hdr;						// Salt
	m[1152 +: 32] = idx + 1;
	inner = sha256_words(m, 37);
	m = '0;
	for (int j = 0; j < 16; j++)
		m[32*j +: 32] = ((j < 8) ? key[32*j +: 32] : 32'h0) ^ {4{`OPAD_BYTE}};
	m[512 +: 256] = inner;
	return sha256_words(m, 24);
endfunction

`endif

// ==== tb_pbkdf_engine.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the PBKDF2-HMAC-SHA256 engine
// Random headers and nonces checked against a software model
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_pbkdf_engine;

	`include "tb_sha256_model.svh"

	localparam int block_timeout = 2000;		// Cycles, one job is about 860

	logic          pbkdf_clk;
	logic          reset;
	logic [255:0]  data1;
	logic [255:0]  data2;
	logic [127:0]  data3;
	logic          load_nonce;
	logic [31:0]   nonce_out;
	logic          block_valid;
	logic [1:0]    block_index;
	logic [255:0]  block_hash;

	integer        seed;
	logic [31:0]   job_nonce;					// Nonce the model expects

	pbkdf_engine u_dut (
		.pbkdf_clk   (pbkdf_clk),
		.reset       (reset),
		.data1       (data1),
		.data2       (data2),
		.data3       (data3),
		.load_nonce  (load_nonce),
		.nonce_out   (nonce_out),
		.block_valid (block_valid),
		.block_index (block_index),
		.block_hash  (block_hash)
	);

	always #50 pbkdf_clk = ~pbkdf_clk;			// 100 ns period

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_equal(input string name, input logic [255:0] exp, input logic [255:0] act);
		if (exp !== act) begin
			$display("** Error %s: expected %h, actual %h", name, exp, act);
			abort_run("Value mismatch, run stopped");
		end
	endtask

	// New random header, applied on the falling edge
	task automatic new_header();
		for (int i = 0; i < 8; i++) begin
			data1[32*i +: 32] = $random(seed);
			data2[32*i +: 32] = $random(seed);
		end
		for (int i = 0; i < 4; i++)
			data3[32*i +: 32] = $random(seed);
	endtask

	// Returns at the falling edge of a block_valid cycle
	task automatic wait_block();
		int n;
		n = 0;
		@(negedge pbkdf_clk);
		while (!block_valid) begin
			if (n == block_timeout)
				abort_run("Timeout waiting for a block_valid pulse");
			n++;
			@(negedge pbkdf_clk);
		end
	endtask

	// Blocks 0..count-1 of a job against the model
	task automatic check_blocks(input string name, input logic [31:0] nonce, input int count);
		logic [639:0] hdr;
		hdr = {nonce, data3[95:0], data2, data1};	// Word 0 is data1 low word
		for (int i = 0; i < count; i++) begin
			wait_block();
			check_equal({name, "_index"}, i, block_index);
			check_equal({name, "_hash"}, pbkdf_block(hdr, i), block_hash);
			// Nonce steps together with the block 3 pulse
			check_equal({name, "_nonce"}, (i == 3) ? nonce + 32'd1 : nonce, nonce_out);
		end
	endtask

	// One-cycle load strobe with a fresh header
	task automatic reload();
		@(negedge pbkdf_clk);
		new_header();
		load_nonce = 1'b1;
		@(negedge pbkdf_clk);
		load_nonce = 1'b0;
		job_nonce = data3[127:96];
		check_equal("load_nonce_value", job_nonce, nonce_out);
	endtask

	initial begin
		pbkdf_clk  = 1'b0;
		reset      = 1'b1;
		load_nonce = 1'b0;
		data1      = '0;
		data2      = '0;
		data3      = '0;
		seed       = 32'h5542d718;
		new_header();
		repeat (8) @(posedge pbkdf_clk);
		@(negedge pbkdf_clk);
		reset = 1'b0;
		@(negedge pbkdf_clk);
		check_equal("reset_valid", 0, block_valid);
		check_equal("reset_nonce", 0, nonce_out);

		job_nonce = 32'd0;						// Reset value, not data3
		check_blocks("first_job", job_nonce, 4);
		job_nonce = job_nonce + 32'd1;
		check_blocks("second_job", job_nonce, 4);
		job_nonce = job_nonce + 32'd1;
		check_blocks("third_job", job_nonce, 4);

		for (int r = 0; r < 4; r++) begin
			reload();
			check_blocks("reload_job", job_nonce, 4);
		end

		// Interrupt a running job after block 1
		job_nonce = job_nonce + 32'd1;
		check_blocks("before_mid_load", job_nonce, 2);
		repeat (10) @(negedge pbkdf_clk);
		reload();
		check_blocks("mid_job", job_nonce, 4);

		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== pbkdf_engine.sv ====
////////////////////////////////////////////////////////////////////////////
// PBKDF2-HMAC-SHA256 engine top
// Job sequencer driving one iterative SHA-256 core
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pbkdf_engine (
	input  logic              pbkdf_clk,
	input  logic              reset,
	input  logic [255:0]      data1,
	input  logic [255:0]      data2,
	input  logic [127:0]      data3,
	input  logic              load_nonce,	// Strobe, nonce from data3[127:96]
	output pbkdf_pkg::word_t  nonce_out,
	output logic              block_valid,	// Pulse per 256-bit key block
	output logic [1:0]        block_index,
	output pbkdf_pkg::hash_t  block_hash
);

	pbkdf_pkg::hash_t   chain_in;
	pbkdf_pkg::block_t  msg_in;
	pbkdf_pkg::hash_t   digest;
	logic               start;
	logic               done;

	pbkdf_sequencer u_sequencer (
		.pbkdf_clk   (pbkdf_clk),
		.reset       (reset),
		.data1       (data1),
		.data2       (data2),
		.data3       (data3),
		.load_nonce  (load_nonce),
		.digest      (digest),
		.done        (done),
		.chain_in    (chain_in),
		.msg_in      (msg_in),
		.start       (start),
		.nonce_out   (nonce_out),
		.block_valid (block_valid),
		.block_index (block_index),
		.block_hash  (block_hash)
	);

	sha256_round_core u_core (
		.pbkdf_clk (pbkdf_clk),
		.reset     (reset),
		.start     (start),
		.chain_in  (chain_in),
		.msg_in    (msg_in),
		.digest    (digest),
		.done      (done)
	);

endmodule

// ==== pbkdf_sequencer.sv ====
////////////////////////////////////////////////////////////////////////////
// PBKDF2-HMAC-SHA256 job sequencer
// Orders the 13 compressions, builds messages, owns the nonce and key output
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "pbkdf_params.svh"

module pbkdf_sequencer (
	input  logic               pbkdf_clk,
	input  logic               reset,
	input  logic [255:0]       data1,		// Header words 0..7
	input  logic [255:0]       data2,		// Header words 8..15
	input  logic [127:0]       data3,		// Header words 16..18 and nonce seed
	input  logic               load_nonce,
	input  pbkdf_pkg::hash_t   digest,
	input  logic               done,
	output pbkdf_pkg::hash_t   chain_in,
	output pbkdf_pkg::block_t  msg_in,
	output logic               start,
	output pbkdf_pkg::word_t   nonce_out,
	output logic               block_valid,
	output logic [1:0]         block_index,
	output pbkdf_pkg::hash_t   block_hash
);

	pbkdf_pkg::seq_state_t  state;
	pbkdf_pkg::seq_state_t  next_state;
	logic                   issue;			// Launch a compression next cycle
	pbkdf_pkg::hash_t       next_chain;
	pbkdf_pkg::block_t      next_msg;
	logic                   core_busy;		// Core running, possibly abandoned
	logic [1:0]             blk_cnt;		// Key block in progress
	logic                   last_blk;
	logic                   job_end;

	pbkdf_pkg::hash_t       khash;			// Key hash of the header
	pbkdf_pkg::hash_t       ihash;			// State after key xor ipad and salt head
	pbkdf_pkg::hash_t       ohash;			// State after key xor opad
	pbkdf_pkg::word_t       salt_ctr;

	pbkdf_pkg::block_t      hdr_head;
	pbkdf_pkg::block_t      hdr_tail;
	pbkdf_pkg::block_t      salt_msg;
	pbkdf_pkg::block_t      ipad_msg;
	pbkdf_pkg::block_t      opad_msg;
	pbkdf_pkg::block_t      outer_msg;

	assign last_blk = (blk_cnt == 2'(`PBKDF_BLOCKS - 1));
	assign job_end  = done && !load_nonce && last_blk &&
	                  (state == pbkdf_pkg::st_block_outer);

	// Counter is 1-based, outer state already points at the following block
	assign salt_ctr = 32'(blk_cnt) +
	                  ((state == pbkdf_pkg::st_block_outer) ? 32'd2 : 32'd1);

	assign hdr_head  = {data2, data1};
	assign hdr_tail  = {`HDR_TAIL_PAD, nonce_out, data3[95:0]};
	assign salt_msg  = {`SALT_TAIL_PAD, salt_ctr, nonce_out, data3[95:0]};
	assign ipad_msg  = {256'd0, digest} ^ {64{`IPAD_BYTE}};	// Key fresh from the core
	assign opad_msg  = {256'd0, khash} ^ {64{`OPAD_BYTE}};
	assign outer_msg = {`OUTER_PAD, digest};					// Inner digest fresh from the core

	always_comb begin
		issue      = 1'b0;
		next_state = state;
		next_chain = `SHA_IV;
		next_msg   = hdr_head;
		case (state)
			pbkdf_pkg::st_idle: begin
				if (!core_busy || done) begin	// Core free next cycle
					issue      = 1'b1;
					next_state = pbkdf_pkg::st_key_first;
				end
			end
			pbkdf_pkg::st_key_first: begin
				if (done) begin
					issue      = 1'b1;
					next_chain = digest;
					next_msg   = hdr_tail;
					next_state = pbkdf_pkg::st_key_second;
				end
			end
			pbkdf_pkg::st_key_second: begin
				if (done) begin
					issue      = 1'b1;
					next_msg   = ipad_msg;
					next_state = pbkdf_pkg::st_ipad_first;
				end
			end
			pbkdf_pkg::st_ipad_first: begin
				if (done) begin
					issue      = 1'b1;
					next_chain = digest;		// Header again, now as salt
					next_state = pbkdf_pkg::st_ipad_second;
				end
			end
			pbkdf_pkg::st_ipad_second: begin
				if (done) begin
					issue      = 1'b1;
					next_msg   = opad_msg;
					next_state = pbkdf_pkg::st_opad;
				end
			end
			pbkdf_pkg::st_opad: begin
				if (done) begin
					issue      = 1'b1;
					next_chain = ihash;
					next_msg   = salt_msg;
					next_state = pbkdf_pkg::st_block_inner;
				end
			end
			pbkdf_pkg::st_block_inner: begin
				if (done) begin
					issue      = 1'b1;
					next_chain = ohash;
					next_msg   = outer_msg;
					next_state = pbkdf_pkg::st_block_outer;
				end
			end
			pbkdf_pkg::st_block_outer: begin
				if (done) begin
					issue      = 1'b1;
					next_state = pbkdf_pkg::st_emit;
					if (!last_blk) begin		// Else next job from the IV
						next_chain = ihash;
						next_msg   = salt_msg;
					end
				end
			end
			pbkdf_pkg::st_emit: begin
				next_state = last_blk ? pbkdf_pkg::st_key_first : pbkdf_pkg::st_block_inner;
			end
			default: next_state = pbkdf_pkg::st_idle;
		endcase
		if (load_nonce) begin			// Abandon and restart from the key hash
			issue      = 1'b0;
			next_state = pbkdf_pkg::st_idle;
		end
	end

	always_ff @(posedge pbkdf_clk) begin
		if (reset) begin
			state     <= pbkdf_pkg::st_idle;
			start     <= 1'b0;
			core_busy <= 1'b0;
			blk_cnt   <= '0;
			nonce_out <= '0;
		end else begin
			state <= next_state;
			start <= issue;
			if (start)
				core_busy <= 1'b1;
			else if (done)
				core_busy <= 1'b0;
			if (load_nonce) begin
				nonce_out <= data3[127:96];
				blk_cnt   <= '0;
			end else begin
				if (job_end)
					nonce_out <= nonce_out + 1'b1;	// Visible with the block 3 pulse
				if (state == pbkdf_pkg::st_emit)
					blk_cnt <= blk_cnt + 1'b1;		// Wraps to 0 after block 3
			end
		end
	end

	always_ff @(posedge pbkdf_clk) begin
		if (issue) begin
			chain_in <= next_chain;			// Stable until the next launch
			msg_in   <= next_msg;
		end
		if (done && !load_nonce) begin
			case (state)
				pbkdf_pkg::st_key_second:  khash      <= digest;
				pbkdf_pkg::st_ipad_second: ihash      <= digest;
				pbkdf_pkg::st_opad:        ohash      <= digest;
				pbkdf_pkg::st_block_outer: block_hash <= digest;
				default: ;
			endcase
		end
	end

	assign block_valid = (state == pbkdf_pkg::st_emit);
	assign block_index = blk_cnt;

	// Nonce steps together with the last key block
	a_nonce_step: assert property (@(posedge pbkdf_clk) disable iff (reset)
		block_valid && (block_index == 2'd3) |-> (nonce_out == $past(nonce_out) + 32'd1));

	a_no_start_idle: assert property (@(posedge pbkdf_clk) disable iff (reset)
		(state == pbkdf_pkg::st_idle) |-> !start);

endmodule

// ==== sha256_round_core.sv ====
////////////////////////////////////////////////////////////////////////////
// Iterative SHA-256 compression
// One round per clock, then the chaining state is added in
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "pbkdf_params.svh"

module sha256_round_core (
	input  logic               pbkdf_clk,
	input  logic               reset,
	input  logic               start,		// One-cycle launch
	input  pbkdf_pkg::hash_t   chain_in,	// Held until done
	input  pbkdf_pkg::block_t  msg_in,		// Held until done
	output pbkdf_pkg::hash_t   digest,
	output logic               done
);

	localparam int RW = $clog2(`SHA_ROUNDS);

	pbkdf_pkg::hash_t   work;			// Working vars a..h, a lowest
	pbkdf_pkg::block_t  sched;			// Sliding window W[t..t+15]
	logic [RW-1:0]      rnd;			// Next round to run
	logic               busy;			// Rounds 1..63 in progress
	logic               fin;			// Final addition cycle

	logic [RW-1:0]      cur_rnd;
	pbkdf_pkg::word_t   k;
	pbkdf_pkg::hash_t   cur_work;
	pbkdf_pkg::hash_t   next_work;
	pbkdf_pkg::block_t  cur_sched;
	pbkdf_pkg::block_t  next_sched;
	pbkdf_pkg::hash_t   sum;

	function automatic pbkdf_pkg::word_t rotr(input pbkdf_pkg::word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	// Round 0 runs straight off the inputs in the start cycle
	assign cur_rnd   = busy ? rnd : '0;
	assign cur_work  = busy ? work : chain_in;
	assign cur_sched = busy ? sched : msg_in;

	sha256_k_rom u_k_rom (
		.round (cur_rnd),
		.k     (k)
	);

	always_comb begin
		pbkdf_pkg::word_t a, b, c, d, e, f, g, h;
		pbkdf_pkg::word_t bs0, bs1, ch, maj, t1, t2;
		pbkdf_pkg::word_t w1, w9, w14, ss0, ss1, w_new;
		a = cur_work[31:0];
		b = cur_work[63:32];
		c = cur_work[95:64];
		d = cur_work[127:96];
		e = cur_work[159:128];
		f = cur_work[191:160];
		g = cur_work[223:192];
		h = cur_work[255:224];
		bs1 = rotr(e, 6) ^ rotr(e, 11) ^ rotr(e, 25);	// Sigma1
		ch  = (e & f) ^ (~e & g);
		t1  = h + bs1 + ch + k + cur_sched[31:0];		// W[t] in low word
		bs0 = rotr(a, 2) ^ rotr(a, 13) ^ rotr(a, 22);	// Sigma0
		maj = (a & b) ^ (a & c) ^ (b & c);
		t2  = bs0 + maj;
		next_work = {g, f, e, d + t1, c, b, a, t1 + t2};
		// Expand W[t+16] and slide the window down one word
		w1  = cur_sched[63:32];
		w9  = cur_sched[319:288];
		w14 = cur_sched[479:448];
		ss0 = rotr(w1, 7) ^ rotr(w1, 18) ^ (w1 >> 3);
		ss1 = rotr(w14, 17) ^ rotr(w14, 19) ^ (w14 >> 10);
		w_new = ss1 + w9 + ss0 + cur_sched[31:0];
		next_sched = {w_new, cur_sched[511:32]};
	end

	// Feed-forward of the chaining state
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			sum[32*i +: 32] = chain_in[32*i +: 32] + work[32*i +: 32];
		end
	end

	always_ff @(posedge pbkdf_clk) begin
		if (reset) begin
			busy <= 1'b0;
			fin  <= 1'b0;
			done <= 1'b0;
			rnd  <= '0;
		end else begin
			done <= fin;				// Pulse after the add
			fin  <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				rnd  <= RW'(1);			// Round 0 done this edge
			end else if (busy) begin
				rnd <= rnd + 1'b1;
				if (rnd == RW'(`SHA_ROUNDS - 1)) begin
					busy <= 1'b0;		// Last round
					fin  <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge pbkdf_clk) begin
		if (start || busy) begin
			work  <= next_work;
			sched <= next_sched;
		end
		if (fin)
			digest <= sum;				// Held until the next add
	end

	// No launch while a compression is still running
	a_no_overlap: assert property (@(posedge pbkdf_clk) disable iff (reset)
		start |-> !(busy || fin));

	// Result always lands a fixed distance after the launch
	a_done_latency: assert property (@(posedge pbkdf_clk) disable iff (reset)
		start |-> ##(`SHA_ROUNDS + 1) done);

endmodule

// ==== sha256_k_rom.sv ====
////////////////////////////////////////////////////////////////////////////
// SHA-256 round constant table
// Combinational lookup of K by round number
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module sha256_k_rom (
	input  logic [5:0]        round,	// Round 0..63
	output pbkdf_pkg::word_t  k
);

	always_comb begin
		case (round)
			6'd0:  k = 32'h428a2f98;
			6'd1:  k = 32'h71374491;
			6'd2:  k = 32'hb5c0fbcf;
			6'd3:  k = 32'he9b5dba5;
			6'd4:  k = 32'h3956c25b;
			6'd5:  k = 32'h59f111f1;
			6'd6:  k = 32'h923f82a4;
			6'd7:  k = 32'hab1c5ed5;
			6'd8:  k = 32'hd807aa98;
			6'd9:  k = 32'h12835b01;
			6'd10: k = 32'h243185be;
			6'd11: k = 32'h550c7dc3;
			6'd12: k = 32'h72be5d74;
			6'd13: k = 32'h80deb1fe;
			6'd14: k = 32'h9bdc06a7;
			6'd15: k = 32'hc19bf174;
			6'd16: k = 32'he49b69c1;
			6'd17: k = 32'hefbe4786;
			6'd18: k = 32'h0fc19dc6;
			6'd19: k = 32'h240ca1cc;
			6'd20: k = 32'h2de92c6f;
			6'd21: k = 32'h4a7484aa;
			6'd22: k = 32'h5cb0a9dc;
			6'd23: k = 32'h76f988da;
			6'd24: k = 32'h983e5152;
			6'd25: k = 32'ha831c66d;
			6'd26: k = 32'hb00327c8;
			6'd27: k = 32'hbf597fc7;
			6'd28: k = 32'hc6e00bf3;
			6'd29: k = 32'hd5a79147;
			6'd30: k = 32'h06ca6351;
			6'd31: k = 32'h14292967;
			6'd32: k = 32'h27b70a85;
			6'd33: k = 32'h2e1b2138;
			6'd34: k = 32'h4d2c6dfc;
			6'd35: k = 32'h53380d13;
			6'd36: k = 32'h650a7354;
			6'd37: k = 32'h766a0abb;
			6'd38: k = 32'h81c2c92e;
			6'd39: k = 32'h92722c85;
			6'd40: k = 32'ha2bfe8a1;
			6'd41: k = 32'ha81a664b;
			6'd42: k = 32'hc24b8b70;
			6'd43: k = 32'hc76c51a3;
			6'd44: k = 32'hd192e819;
			6'd45: k = 32'hd6990624;
			6'd46: k = 32'hf40e3585;
			6'd47: k = 32'h106aa070;
			6'd48: k = 32'h19a4c116;
			6'd49: k = 32'h1e376c08;
			6'd50: k = 32'h2748774c;
			6'd51: k = 32'h34b0bcb5;
			6'd52: k = 32'h391c0cb3;
			6'd53: k = 32'h4ed8aa4a;
			6'd54: k = 32'h5b9cca4f;
			6'd55: k = 32'h682e6ff3;
			6'd56: k = 32'h748f82ee;
			6'd57: k = 32'h78a5636f;
			6'd58: k = 32'h84c87814;
			6'd59: k = 32'h8cc70208;
			6'd60: k = 32'h90befffa;
			6'd61: k = 32'ha4506ceb;
			6'd62: k = 32'hbef9a3f7;
			default: k = 32'hc67178f2;	// Round 63
		endcase
	end

endmodule

// ==== pbkdf_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// PBKDF2 engine types
// SHA-256 word, state and block types plus the sequencer phases
////////////////////////////////////////////////////////////////////////////
package pbkdf_pkg;

	// One SHA-256 word
	typedef logic [31:0] word_t;

	// Chaining state or digest, word 0 (variable a) in bits 31:0
	typedef logic [255:0] hash_t;

	// Message block, first big-endian word in bits 31:0
	typedef logic [511:0] block_t;

	// Phase of the job, named after the compression in flight
	typedef enum logic [3:0] {
		st_idle,				// Waiting for the core after reset or load
		st_key_first,			// Header words 0..15
		st_key_second,			// Header tail with nonce, gives key hash
		st_ipad_first,			// Key xor ipad from IV
		st_ipad_second,			// Header as salt head, gives inner state
		st_opad,				// Key xor opad from IV, gives outer state
		st_block_inner,			// Salt tail plus block counter
		st_block_outer,			// Inner digest under outer state
		st_emit					// One cycle with block_valid high
	} seq_state_t;

endpackage

// ==== pbkdf_params.svh ====
////////////////////////////////////////////////////////////////////////////
// PBKDF2-HMAC-SHA256 engine constants
// Round and block counts, SHA-256 IV, HMAC pad bytes and message padding
////////////////////////////////////////////////////////////////////////////
`ifndef PBKDF_PARAMS_SVH
`define PBKDF_PARAMS_SVH

// Rounds per SHA-256 compression
`define SHA_ROUNDS 64

// Derived key blocks per job, 4 x 32 bytes
`define PBKDF_BLOCKS 4

// SHA-256 initial state, variable a in the low word
`define SHA_IV 256'h5be0cd19_1f83d9ab_9b05688c_510e527f_a54ff53a_3c6ef372_bb67ae85_6a09e667

// HMAC inner and outer pad bytes
`define IPAD_BYTE 8'h36
`define OPAD_BYTE 8'h5c

// Words 4..15 after the 16-byte header tail, 80 bytes total
`define HDR_TAIL_PAD {32'h00000280, 320'd0, 32'h80000000}

// Words 5..15 after salt tail and counter, 64 + 84 bytes total
`define SALT_TAIL_PAD {32'h000004a0, 288'd0, 32'h80000000}

// Words 8..15 after a 32-byte digest, 64 + 32 bytes total
`define OUTER_PAD {32'h00000300, 192'd0, 32'h80000000}

`endif
